// File: project.f
hw/div_pkg.sv
hw/div_stage_if.sv
hw/div_row_stage.sv
hw/div_array_pipe.sv
hw/div_apb_regs.sv
hw/approx_div_top.sv
verification/div_clk_gen.sv
verification/div_asserts.sv
verification/div_tb.sv

// File: verification/div_tb.sv
module div_tb;
  timeunit 1ns;
  timeprecision 100ps;

  // mirrors the defaults of approx_div_top
  localparam int approx_rows = 6;
  localparam int fifo_depth = 4;
  localparam int poll_limit = 100;

  logic clk;
  logic reset;
  logic psel;
  logic penable;
  logic pwrite;
  logic [3:0] paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic pready;
  logic pslverr;

  logic [31:0] rng_state;
  div_pkg::result_t expect_q [$];
  div_pkg::result_t read_value;
  event result_read;

  div_clk_gen u_clk (
    .clk(clk),
    .reset(reset)
  );

  approx_div_top uut (
    .clk(clk),
    .reset(reset),
    .psel(psel),
    .penable(penable),
    .pwrite(pwrite),
    .paddr(paddr),
    .pwdata(pwdata),
    .prdata(prdata),
    .pready(pready),
    .pslverr(pslverr)
  );

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Regression failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %0t ns %s got 0x%0h expected 0x%0h", $time, name, got, exp);
      stop_run("value mismatch");
    end
  endtask

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // restoring array with one row per quotient bit from the msb row down
  function automatic div_pkg::result_t ref_div(input logic [15:0] dvd, input logic [7:0] dvs);
    div_pkg::result_t r;
    logic top;
    logic [7:0] win;
    logic [6:0] rest;
    logic [7:0] d;
    logic b;
    logic q;
    top = dvd[15];
    win = dvd[14:7];
    rest = dvd[6:0];
    d = '0;
    r = '0;
    for (int k = 7; k >= 0; k--) begin
      b = 1'b0;
      for (int j = 0; j < 8; j++) begin
        if (k < approx_rows) begin
          d[j] = win[j] | b;
          b = win[j];
        end else begin
          d[j] = win[j] ^ dvs[j] ^ b;
          b = (!win[j] && dvs[j]) || ((win[j] == dvs[j]) && b);
        end
      end
      q = top | ~b;
      r.quotient[k] = q;
      if (!q) begin
        d = win;
      end
      top = d[7];
      win = {d[6:0], rest[6]};
      rest = rest << 1;
    end
    r.remainder = d;
    return r;
  endfunction

  task automatic apb_xfer(input logic wr, input logic [3:0] addr, input logic [31:0] data,
                          output logic [31:0] rdata, output logic err);
    @(posedge clk);
    psel <= 1'b1;
    penable <= 1'b0;
    pwrite <= wr;
    paddr <= addr;
    pwdata <= data;
    @(posedge clk);
    penable <= 1'b1;
    // sample mid access phase where outputs are settled
    @(negedge clk);
    rdata = prdata;
    err = pslverr;
    check("pready", pready, 1'b1);
    @(posedge clk);
    psel <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic launch(input logic [15:0] dvd, input logic [7:0] dvs, input logic exp_err);
    logic [31:0] rd;
    logic err;
    apb_xfer(1'b1, div_pkg::addr_operand, {8'h00, dvs, dvd}, rd, err);
    check("pslverr", err, exp_err);
    if (!err) begin
      expect_q.push_back(ref_div(dvd, dvs));
    end
  endtask

  task automatic read_result(input logic exp_err);
    logic [31:0] rd;
    logic err;
    apb_xfer(1'b0, div_pkg::addr_result, 32'h0, rd, err);
    check("pslverr", err, exp_err);
    if (err) begin
      check("prdata", rd, 32'h0);
    end else begin
      read_value = rd[15:0];
      -> result_read;
    end
  endtask

  task automatic wait_level(input int n);
    logic [31:0] rd;
    logic err;
    int polls;
    polls = 0;
    rd = '0;
    while (rd[3:0] < n) begin
      if (polls == poll_limit) begin
        stop_run("timeout while waiting for results in the FIFO");
      end else begin
        apb_xfer(1'b0, div_pkg::addr_status, 32'h0, rd, err);
        polls++;
      end
    end
  endtask

  always @(result_read) begin
    if (expect_q.size() == 0) begin
      stop_run("result read with no division outstanding");
    end else begin
      check("quotient", read_value.quotient, expect_q[0].quotient);
      check("remainder", read_value.remainder, expect_q[0].remainder);
      void'(expect_q.pop_front());
    end
  end

  always @(posedge clk) begin
    if (uut.u_regs.u_asserts.fail_count != 0) begin
      stop_run("an assertion on the register block failed");
    end
  end

  initial begin
    logic [31:0] rd;
    logic err;
    logic [23:0] picks [6];
    int waits;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    rng_state = 32'h5ee3;
    picks = '{{8'd1, 16'd200}, {8'd255, 16'hfe01}, {8'd7, 16'd100},
              {8'd10, 16'd1000}, {8'd77, 16'd12345}, {8'd255, 16'd254}};
    waits = 0;
    while (reset !== 1'b0) begin
      if (waits == 20) begin
        stop_run("reset never released");
      end else begin
        @(posedge clk);
        waits++;
      end
    end

    apb_xfer(1'b0, div_pkg::addr_status, 32'h0, rd, err);
    check("status", rd, 32'h0);
    check("pslverr", err, 1'b0);
    read_result(1'b1);

    foreach (picks[i]) begin
      launch(picks[i][15:0], picks[i][23:16], 1'b0);
      wait_level(1);
      read_result(1'b0);
    end

    for (int i = 0; i < 200; i++) begin
      rng_state = xorshift(rng_state);
      launch(rng_state[15:0], rng_state[23:16], 1'b0);
      wait_level(1);
      read_result(1'b0);
    end

    // launches land three cycles apart so two are still in the array at the status read
    for (int i = 0; i < 4; i++) begin
      rng_state = xorshift(rng_state);
      launch(rng_state[15:0], rng_state[23:16], 1'b0);
    end
    apb_xfer(1'b0, div_pkg::addr_status, 32'h0, rd, err);
    check("status", rd, 32'h22);
    wait_level(4);
    repeat (4) read_result(1'b0);

    for (int i = 0; i < fifo_depth; i++) begin
      rng_state = xorshift(rng_state);
      launch(rng_state[15:0], rng_state[23:16], 1'b0);
    end
    wait_level(fifo_depth);
    launch(16'h4321, 8'h21, 1'b1);
    apb_xfer(1'b0, div_pkg::addr_status, 32'h0, rd, err);
    check("status", rd, fifo_depth);
    read_result(1'b0);
    launch(16'h4321, 8'h21, 1'b0);
    wait_level(fifo_depth);
    repeat (fifo_depth) read_result(1'b0);
    read_result(1'b1);

    // no divide-by-zero special case
    launch(16'h1234, 8'h00, 1'b0);
    launch(16'h0000, 8'h00, 1'b0);
    wait_level(2);
    repeat (2) read_result(1'b0);

    if (uut.u_regs.u_asserts.fail_count != 0) begin
      stop_run("assertion failures were reported during the run");
    end else begin
      $display("Regression passed");
      $finish;
    end
  end

endmodule

// File: verification/div_asserts.sv
module div_asserts #(
  parameter int FIFO_DEPTH = 4
) (
  input logic clk,
  input logic reset,
  input logic psel,
  input logic penable,
  input logic pwrite,
  input logic [3:0] paddr,
  input logic pready,
  input logic pslverr,
  input logic start,
  input logic [$clog2(FIFO_DEPTH + 1)-1:0] level
);
  timeunit 1ns;
  timeprecision 100ps;

  int fail_count = 0;

  logic access;
  logic refused;

  assign access = psel && penable;
  assign refused = access && pwrite && (paddr == div_pkg::addr_operand) && pslverr;

  a_pready_high: assert property (@(posedge clk) disable iff (reset) pready)
    else begin
      fail_count++;
      $error("pready went low");
    end

  a_level_bound: assert property (@(posedge clk) disable iff (reset) level <= FIFO_DEPTH)
    else begin
      fail_count++;
      $error("fifo level above depth");
    end

  // a refused launch must not reach the pipe
  a_no_start_on_refuse: assert property (@(posedge clk) disable iff (reset) refused |-> !start)
    else begin
      fail_count++;
      $error("start raised on a refused operand write");
    end

  a_err_in_access: assert property (@(posedge clk) disable iff (reset) !access |-> !pslverr)
    else begin
      fail_count++;
      $error("pslverr outside an access phase");
    end

endmodule

bind div_apb_regs div_asserts #(
  .FIFO_DEPTH(FIFO_DEPTH)
) u_asserts (
  .clk(clk),
  .reset(reset),
  .psel(psel),
  .penable(penable),
  .pwrite(pwrite),
  .paddr(paddr),
  .pready(pready),
  .pslverr(pslverr),
  .start(start),
  .level(level)
);

// File: verification/div_clk_gen.sv
module div_clk_gen (
  output logic clk,
  output logic reset
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  initial begin
    reset = 1'b1;
    repeat (4) @(posedge clk);
    reset <= 1'b0;
  end

endmodule

// File: hw/approx_div_top.sv
module approx_div_top #(
  parameter int APPROX_ROWS = 6,
  parameter int FIFO_DEPTH = 4
) (
  input logic clk,
  input logic reset,
  input logic psel,
  input logic penable,
  input logic pwrite,
  input logic [3:0] paddr,
  input logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic pready,
  output logic pslverr
);

  logic start;
  logic [div_pkg::dividend_w-1:0] dividend;
  logic [div_pkg::divisor_w-1:0] divisor;
  logic done;
  div_pkg::result_t result;

  div_apb_regs #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) u_regs (
    .clk(clk),
    .reset(reset),
    .psel(psel),
    .penable(penable),
    .pwrite(pwrite),
    .paddr(paddr),
    .pwdata(pwdata),
    .prdata(prdata),
    .pready(pready),
    .pslverr(pslverr),
    .start(start),
    .dividend(dividend),
    .divisor(divisor),
    .done(done),
    .result(result)
  );

  div_array_pipe #(
    .APPROX_ROWS(APPROX_ROWS)
  ) u_pipe (
    .clk(clk),
    .reset(reset),
    .start(start),
    .dividend(dividend),
    .divisor(divisor),
    .done(done),
    .result(result)
  );

endmodule

// File: hw/div_apb_regs.sv
module div_apb_regs #(
  parameter int FIFO_DEPTH = 4
) (
  input logic clk,
  input logic reset,
  input logic psel,
  input logic penable,
  input logic pwrite,
  input logic [3:0] paddr,
  input logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic pready,
  output logic pslverr,
  output logic start,
  output logic [div_pkg::dividend_w-1:0] dividend,
  output logic [div_pkg::divisor_w-1:0] divisor,
  input logic done,
  input div_pkg::result_t result
);

  localparam int cnt_w = $clog2(FIFO_DEPTH + 1);
  localparam int ptr_w = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int res_w = $bits(div_pkg::result_t);

  logic access;
  logic wr_operand;
  logic rd_result;
  logic no_room;
  logic fifo_empty;
  logic pop;
  logic [cnt_w-1:0] inflight;
  logic [cnt_w-1:0] level;
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  div_pkg::result_t fifo_mem [FIFO_DEPTH];

  function automatic logic [ptr_w-1:0] bump(input logic [ptr_w-1:0] p);
    return (p == ptr_w'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign access = psel & penable;
  assign wr_operand = access & pwrite & (paddr == div_pkg::addr_operand);
  assign rd_result = access & ~pwrite & (paddr == div_pkg::addr_result);

  // every division in flight already owns a fifo slot
  assign no_room = (inflight + level) == FIFO_DEPTH;
  assign fifo_empty = (level == '0);

  assign start = wr_operand & ~no_room;
  assign dividend = pwdata[div_pkg::dividend_w-1:0];
  assign divisor = pwdata[div_pkg::dividend_w +: div_pkg::divisor_w];

  assign pop = rd_result & ~fifo_empty;

  assign pready = 1'b1;
  assign pslverr = (wr_operand & no_room) | (rd_result & fifo_empty);

  always_comb begin
    prdata = '0;
    if (access && !pwrite) begin
      case (paddr)
        div_pkg::addr_result: begin
          if (!fifo_empty) begin
            prdata[res_w-1:0] = fifo_mem[rd_ptr];
          end
        end
        div_pkg::addr_status: begin
          prdata[3:0] = 4'(level);
          prdata[7:4] = 4'(inflight);
        end
        default: begin
          prdata = '0;
        end
      endcase
    end
  end

  // up on launch, down when the pipe hands a result over
  always_ff @(posedge clk) begin
    if (reset) begin
      inflight <= '0;
    end else if (start && !done) begin
      inflight <= inflight + 1'b1;
    end else if (done && !start) begin
      inflight <= inflight - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
    end else if (done) begin
      wr_ptr <= bump(wr_ptr);
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      rd_ptr <= '0;
    end else if (pop) begin
      rd_ptr <= bump(rd_ptr);
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      level <= '0;
    end else if (done && !pop) begin
      level <= level + 1'b1;
    end else if (pop && !done) begin
      level <= level - 1'b1;
    end
  end

  // admission keeps a push from ever landing on a full fifo
  always_ff @(posedge clk) begin
    if (done) begin
      fifo_mem[wr_ptr] <= result;
    end
  end

endmodule

// File: hw/div_array_pipe.sv
module div_array_pipe #(
  parameter int APPROX_ROWS = 6
) (
  input logic clk,
  input logic reset,
  input logic start,
  input logic [div_pkg::dividend_w-1:0] dividend,
  input logic [div_pkg::divisor_w-1:0] divisor,
  output logic done,
  output div_pkg::result_t result
);

  localparam int n = div_pkg::n_stages;
  localparam int dw = div_pkg::dividend_w;

  div_stage_if link [0:n] ();

  // first window takes dividend bits 14..7, bit 15 rides as top
  assign link[0].valid = start;
  assign link[0].top = dividend[dw-1];
  assign link[0].rem = dividend[dw-2 -: div_pkg::divisor_w];
  assign link[0].low = dividend[div_pkg::low_w-1:0];
  assign link[0].divisor = divisor;
  assign link[0].quotient = '0;

  // row i produces quotient bit n-1-i
  for (genvar i = 0; i < n; i++) begin : g_row
    localparam int bit_idx = n - 1 - i;

    div_row_stage #(
      .APPROX(bit_idx < APPROX_ROWS),
      .BIT(bit_idx)
    ) u_row (
      .clk(clk),
      .reset(reset),
      .up(link[i]),
      .down(link[i+1])
    );
  end

  assign done = link[n].valid;
  assign result.quotient = link[n].quotient;
  assign result.remainder = link[n].rem;

endmodule

// File: hw/div_row_stage.sv
module div_row_stage #(
  parameter bit APPROX = 1'b0,
  parameter int BIT = 0
) (
  input logic clk,
  input logic reset,
  div_stage_if.dst up,
  div_stage_if.src down
);

  localparam int w = div_pkg::divisor_w;
  localparam int lw = div_pkg::low_w;

  logic [w-1:0] diff;
  logic [w:0] borrow;
  logic q_bit;
  logic [w-1:0] new_rem;
  logic [w-1:0] quot_next;
  logic [w-1:0] rem_next;
  logic top_next;
  logic [lw-1:0] low_next;

  // borrow row, lsb column first
  always_comb begin
    borrow[0] = 1'b0;
    for (int j = 0; j < w; j++) begin
      if (APPROX) begin
        // approximate cell ignores the divisor bit
        diff[j] = up.rem[j] | borrow[j];
        borrow[j+1] = up.rem[j];
      end else begin
        diff[j] = up.rem[j] ^ up.divisor[j] ^ borrow[j];
        borrow[j+1] = (~up.rem[j] & up.divisor[j]) |
                      (~(up.rem[j] ^ up.divisor[j]) & borrow[j]);
      end
    end
  end

  assign q_bit = up.top | ~borrow[w];

  // restore when the subtraction did not fit
  assign new_rem = q_bit ? diff : up.rem;

  always_comb begin
    quot_next = up.quotient;
    quot_next[BIT] = q_bit;
  end

  always_comb begin
    if (BIT == 0) begin
      // last row keeps its remainder as the final one
      rem_next = new_rem;
      top_next = 1'b0;
      low_next = up.low;
    end else begin
      rem_next = {new_rem[w-2:0], up.low[lw-1]};
      top_next = new_rem[w-1];
      low_next = {up.low[lw-2:0], 1'b0};
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      down.valid <= 1'b0;
    end else begin
      down.valid <= up.valid;
    end
  end

  always_ff @(posedge clk) begin
    down.top <= top_next;
    down.rem <= rem_next;
    down.low <= low_next;
    down.divisor <= up.divisor;
    down.quotient <= quot_next;
  end

endmodule

// File: hw/div_stage_if.sv
interface div_stage_if;

  logic valid;

  // carried high remainder bit
  logic top;

  // partial remainder window
  logic [div_pkg::divisor_w-1:0] rem;

  // dividend bits still to be shifted in, msb first
  logic [div_pkg::low_w-1:0] low;

  logic [div_pkg::divisor_w-1:0] divisor;

  // bits produced so far
  logic [div_pkg::divisor_w-1:0] quotient;

  modport src (
    output valid, top, rem, low, divisor, quotient
  );

  modport dst (
    input valid, top, rem, low, divisor, quotient
  );

endinterface

// File: hw/div_pkg.sv
package div_pkg;

  // operand and result widths
  localparam int dividend_w = 16;
  localparam int divisor_w = 8;

  // dividend bits left over once the first window is loaded
  localparam int low_w = dividend_w - divisor_w - 1;

  // one pipeline stage per quotient bit
  localparam int n_stages = divisor_w;

  // register offsets
  localparam logic [3:0] addr_operand = 4'h0;
  localparam logic [3:0] addr_result = 4'h4;
  localparam logic [3:0] addr_status = 4'h8;

  // remainder sits above quotient, same as the RESULT word
  typedef struct packed {
    logic [divisor_w-1:0] remainder;
    logic [divisor_w-1:0] quotient;
  } result_t;

endpackage
